//--- Bender.yml
package:
  name: uart_transceiver

sources:
  # design, in compile order
  - files:
      - hdl/uart_pkg.sv
      - hdl/uart_tx.sv
      - hdl/uart_rx.sv
      - hdl/uart_top.sv

  # testbench, the task header sits in test/
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_uart_top.sv

# top modules: tb_uart_top for simulation, uart_top for the design

//--- files.f
+incdir+test
hdl/uart_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_top.sv
test/tb_uart_top.sv

//--- hdl/uart_pkg.sv
package uart_pkg;

    // frame format: start, 8 data lsb first, even parity, stop
    localparam int DATA_BITS      = 8;
    localparam int CLOCKS_PER_BIT = 8;
    localparam int FRAME_BITS     = DATA_BITS + 3;  // start + data + parity + stop
    localparam int SYNC_STAGES    = 3;              // rx input synchronizer depth

    // counter widths
    localparam int BAUD_CNT_W = $clog2(CLOCKS_PER_BIT);
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS);
    localparam int DATA_IDX_W = $clog2(DATA_BITS);

    // terminal counts
    localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLOCKS_PER_BIT - 1);
    localparam logic [BAUD_CNT_W-1:0] HALF_BIT  = BAUD_CNT_W'(CLOCKS_PER_BIT / 2 - 1);
    localparam logic [BIT_CNT_W-1:0]  BIT_LAST  = BIT_CNT_W'(FRAME_BITS - 1);
    localparam logic [DATA_IDX_W-1:0] DATA_LAST = DATA_IDX_W'(DATA_BITS - 1);

    typedef logic [DATA_BITS-1:0] uart_byte_t;

    // receive result, meaningful only while valid is high
    typedef struct packed {
        uart_byte_t data;
        logic       parity_error;  // received parity differs from xor of data
        logic       frame_error;   // stop bit sampled low
    } rx_status_t;

endpackage

//--- hdl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       i_serial_in,
    output logic       o_rx_valid,
    output rx_status_t o_rx_status
);

    enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_PARITY,
        ST_STOP
    } state_q;

    logic [SYNC_STAGES-1:0] sync_q;      // async input synchronizer
    logic                   line_prev_q; // for falling edge detect
    logic                   line;
    logic                   fall;
    logic [BAUD_CNT_W-1:0]  baud_cnt_q;
    logic [DATA_IDX_W-1:0]  bit_idx_q;
    logic                   sample;      // sampling point of current bit
    uart_byte_t             data_q;
    logic                   parity_q;
    logic                   valid_q;
    rx_status_t             status_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q      <= '1;  // idle level, no false start after reset
            line_prev_q <= 1'b1;
        end else begin
            sync_q      <= {sync_q[SYNC_STAGES-2:0], i_serial_in};
            line_prev_q <= line;
        end
    end

    assign line = sync_q[SYNC_STAGES-1];
    assign fall = line_prev_q && !line;

    // start bit is checked half a bit in, the rest a full bit apart
    assign sample = (state_q == ST_START) ? (baud_cnt_q == HALF_BIT)
                                          : (baud_cnt_q == BAUD_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= ST_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= 1'b0;  // single-cycle pulse
            if (state_q == ST_IDLE || sample) begin
                baud_cnt_q <= '0;
            end else begin
                baud_cnt_q <= baud_cnt_q + 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    if (fall) begin
                        state_q <= ST_START;
                    end
                end
                ST_START: begin
                    if (sample) begin
                        bit_idx_q <= '0;
                        state_q   <= line ? ST_IDLE : ST_DATA;  // glitch goes back to idle
                    end
                end
                ST_DATA: begin
                    if (sample) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == DATA_LAST) begin
                            state_q <= ST_PARITY;
                        end
                    end
                end
                ST_PARITY: begin
                    if (sample) begin
                        state_q <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (sample) begin
                        valid_q <= 1'b1;
                        state_q <= ST_IDLE;  // ready for a back-to-back frame
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (sample) begin
            case (state_q)
                ST_DATA:   data_q   <= {line, data_q[DATA_BITS-1:1]};  // lsb first
                ST_PARITY: parity_q <= line;
                ST_STOP: begin
                    status_q.data         <= data_q;
                    status_q.parity_error <= (^data_q) ^ parity_q;
                    status_q.frame_error  <= !line;
                end
                default: ;
            endcase
        end
    end

    assign o_rx_valid  = valid_q;
    assign o_rx_status = status_q;

    a_valid_pulse: assert property (
        @(posedge clk) disable iff (reset)
        o_rx_valid |=> !o_rx_valid
    ) else $error("uart_rx: valid held longer than one cycle");

    // a report only comes out of the stop bit check
    a_valid_from_stop: assert property (
        @(posedge clk) disable iff (reset)
        $rose(o_rx_valid) |-> $past(state_q == ST_STOP)
    ) else $error("uart_rx: valid raised outside stop state");

endmodule

//--- hdl/uart_top.sv
`timescale 1ns/1ps

module uart_top
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    // transmit side
    input  logic       i_enable,
    input  uart_byte_t i_data,
    output logic       o_busy,
    output logic       o_serial_out,
    // receive side
    input  logic       i_loopback,   // high routes tx line into rx
    input  logic       i_serial_in,  // external line, used when loopback is low
    output logic       o_rx_valid,
    output rx_status_t o_rx_status
);

    logic tx_line;
    logic rx_line;

    uart_tx uart_tx_i (
        .clk          (clk),
        .reset        (reset),
        .i_enable     (i_enable),
        .i_data       (i_data),
        .o_busy       (o_busy),
        .o_serial_out (tx_line)
    );

    // self-test path or external line
    assign rx_line      = i_loopback ? tx_line : i_serial_in;
    assign o_serial_out = tx_line;

    uart_rx uart_rx_i (
        .clk         (clk),
        .reset       (reset),
        .i_serial_in (rx_line),
        .o_rx_valid  (o_rx_valid),
        .o_rx_status (o_rx_status)
    );

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       i_enable,
    input  uart_byte_t i_data,
    output logic       o_busy,
    output logic       o_serial_out
);

    logic [FRAME_BITS-1:0] shift_q;     // whole frame, bit 0 is on the line
    logic [BAUD_CNT_W-1:0] baud_cnt_q;  // cycles within current bit
    logic [BIT_CNT_W-1:0]  bit_cnt_q;   // bits already sent in frame
    logic                  busy_q;
    logic                  start;
    logic                  bit_end;
    logic                  parity;

    assign start   = i_enable && !busy_q;      // enable ignored mid-frame
    assign bit_end = (baud_cnt_q == BAUD_LAST);
    assign parity  = ^i_data;                  // even parity over data

    // frame timing
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q     <= 1'b0;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else if (start) begin
            busy_q     <= 1'b1;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
        end else if (busy_q) begin
            if (bit_end) begin
                baud_cnt_q <= '0;
                if (bit_cnt_q == BIT_LAST) begin
                    busy_q    <= 1'b0;  // stop bit done
                    bit_cnt_q <= '0;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
            end else begin
                baud_cnt_q <= baud_cnt_q + 1'b1;
            end
        end
    end

    // the shift register holds the line level too, so it comes up all ones
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_q <= '1;
        end else if (start) begin
            shift_q <= {1'b1, parity, i_data, 1'b0};  // stop, parity, data, start
        end else if (busy_q && bit_end) begin
            shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};  // fill with idle level
        end
    end

    assign o_busy       = busy_q;
    assign o_serial_out = shift_q[0];

    // the line is at idle level whenever no frame is in flight
    a_idle_high: assert property (
        @(posedge clk) disable iff (reset)
        !o_busy |-> o_serial_out
    ) else $error("uart_tx: line low while not busy");

    // first cycle of a frame only ever follows an idle cycle
    a_no_restart: assert property (
        @(posedge clk) disable iff (reset)
        (o_busy && bit_cnt_q == '0 && baud_cnt_q == '0) |-> $past(!o_busy)
    ) else $error("uart_tx: frame restarted while busy");

endmodule

//--- test/tb_uart_tasks.svh
// compare one value and count the check
task automatic expect_equal(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("** Error at %0t ns: %s expected %0h, got %0h",
                 $time, name, expected, actual);
    end
endtask

task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d errors", name, error_count - errors_before);
    end
endtask

task automatic idle_cycles(input int count);
    repeat (count) @(negedge clk);
endtask

// parity bit that makes the count of ones even
function automatic logic even_parity(input uart_byte_t data);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < DATA_BITS; i++) begin
        ones += data[i];
    end
    return logic'(ones % 2);
endfunction

// line level of bit k of a good frame
function automatic logic frame_bit(input uart_byte_t data, input int k);
    if (k == 0) begin
        return 1'b0;  // start
    end else if (k <= DATA_BITS) begin
        return data[k-1];  // lsb first
    end else if (k == DATA_BITS + 1) begin
        return even_parity(data);
    end
    return 1'b1;  // stop
endfunction

// frame on the external line with chosen parity and stop levels
task automatic drive_frame(input uart_byte_t data, input logic parity_bit,
                           input logic stop_bit);
    int k;
    @(negedge clk);
    for (k = 0; k < FRAME_BITS; k++) begin
        if (k == DATA_BITS + 1) begin
            i_serial_in = parity_bit;
        end else if (k == FRAME_BITS - 1) begin
            i_serial_in = stop_bit;
        end else begin
            i_serial_in = frame_bit(data, k);
        end
        repeat (CLOCKS_PER_BIT) @(negedge clk);
    end
    i_serial_in = 1'b1;
endtask

// status is captured in the valid cycle
task automatic wait_rx_valid(input int max_cycles, output logic seen,
                             output rx_status_t status);
    int n;
    seen   = 1'b0;
    status = '0;
    for (n = 0; n < max_cycles && !seen; n++) begin
        @(negedge clk);
        if (o_rx_valid) begin
            seen   = 1'b1;
            status = o_rx_status;
        end
    end
endtask

// fails in plain words when no report came
task automatic check_rx_report(input string name, input logic seen,
                               input rx_status_t status, input uart_byte_t data,
                               input logic parity_err, input logic frame_err);
    check_count++;
    if (!seen) begin
        error_count++;
        $display("%s: receiver gave no valid pulse within %0d cycles", name, FRAME_CYCLES * 2);
    end else begin
        expect_equal({name, " o_rx_status.data"}, data, status.data);
        expect_equal({name, " o_rx_status.parity_error"}, parity_err, status.parity_error);
        expect_equal({name, " o_rx_status.frame_error"}, frame_err, status.frame_error);
    end
endtask

task automatic receive_and_check(input string name, input uart_byte_t data,
                                 input logic parity_err, input logic frame_err);
    logic       seen;
    rx_status_t status;
    wait_rx_valid(FRAME_CYCLES * 2, seen, status);
    check_rx_report(name, seen, status, data, parity_err, frame_err);
endtask

task automatic reset_idle_levels();
    int errors_before;
    errors_before = error_count;
    repeat (20) begin
        @(negedge clk);
        expect_equal("o_busy", 1'b0, o_busy);
        expect_equal("o_serial_out", 1'b1, o_serial_out);
        expect_equal("o_rx_valid", 1'b0, o_rx_valid);
    end
    report_test("reset state", errors_before);
endtask

task automatic tx_frame_waveform();
    int         errors_before;
    int         busy_cycles;
    uart_byte_t data;
    errors_before = error_count;
    data          = 8'hA5;
    i_loopback    = 1'b0;
    @(negedge clk);
    i_enable = 1'b1;
    i_data   = data;
    @(negedge clk);
    i_enable = 1'b0;
    expect_equal("o_busy after start", 1'b1, o_busy);
    busy_cycles = 0;
    while (o_busy && busy_cycles < FRAME_CYCLES * 2) begin
        if (busy_cycles % CLOCKS_PER_BIT == CLOCKS_PER_BIT / 2) begin
            expect_equal($sformatf("o_serial_out bit %0d", busy_cycles / CLOCKS_PER_BIT),
                         frame_bit(data, busy_cycles / CLOCKS_PER_BIT), o_serial_out);
        end
        i_enable = (busy_cycles == 40);  // mid-frame start, must be ignored
        i_data   = (busy_cycles == 40) ? 8'h3C : data;
        busy_cycles++;
        @(negedge clk);
    end
    i_enable = 1'b0;
    expect_equal("o_busy length", FRAME_CYCLES, busy_cycles);
    expect_equal("o_serial_out after frame", 1'b1, o_serial_out);
    idle_cycles(10);
    expect_equal("o_busy after frame", 1'b0, o_busy);
    report_test("tx waveform", errors_before);
endtask

task automatic loopback_round_trip();
    int         errors_before;
    int         pulses_before;
    uart_byte_t sent_q[$];
    errors_before = error_count;
    pulses_before = valid_count;
    i_loopback    = 1'b1;
    fork
        begin : sender
            int         n;
            uart_byte_t value;
            @(negedge clk);
            for (n = 0; n < LOOPBACK_FRAMES; n++) begin
                while (o_busy) @(negedge clk);
                value    = random_byte();
                i_enable = 1'b1;
                i_data   = value;
                sent_q.push_back(value);
                @(negedge clk);
                i_enable = 1'b0;
            end
        end
        begin : receiver
            int         n;
            logic       seen;
            rx_status_t status;
            uart_byte_t expected;
            for (n = 0; n < LOOPBACK_FRAMES; n++) begin
                wait_rx_valid(FRAME_CYCLES * 2, seen, status);
                expected = (sent_q.size() > 0) ? sent_q.pop_front() : '0;  // oldest byte sent
                check_rx_report($sformatf("loopback byte %0d", n), seen, status,
                                expected, 1'b0, 1'b0);
            end
        end
    join
    idle_cycles(FRAME_CYCLES);
    expect_equal("valid pulse count", LOOPBACK_FRAMES, valid_count - pulses_before);
    i_loopback = 1'b0;
    report_test("loopback round trip", errors_before);
endtask

task automatic parity_error_report();
    int         errors_before;
    uart_byte_t data;
    errors_before = error_count;
    data          = random_byte();
    fork
        drive_frame(data, !even_parity(data), 1'b1);
        receive_and_check("parity frame", data, 1'b1, 1'b0);
    join
    report_test("parity error", errors_before);
endtask

task automatic framing_error_report();
    int errors_before;
    errors_before = error_count;
    fork
        drive_frame(8'h3C, even_parity(8'h3C), 1'b0);  // stop bit low
        receive_and_check("framing frame", 8'h3C, 1'b0, 1'b1);
    join
    report_test("framing error", errors_before);
endtask

task automatic glitch_rejection();
    int         errors_before;
    logic       seen;
    rx_status_t status;
    uart_byte_t data;
    errors_before = error_count;
    @(negedge clk);
    i_serial_in = 1'b0;
    idle_cycles(2);
    i_serial_in = 1'b1;
    wait_rx_valid(FRAME_CYCLES, seen, status);
    expect_equal("o_rx_valid after glitch", 1'b0, seen);
    data = random_byte();
    fork
        drive_frame(data, even_parity(data), 1'b1);
        receive_and_check("frame after glitch", data, 1'b0, 1'b0);
    join
    report_test("glitch rejection", errors_before);
endtask

//--- test/tb_uart_top.sv
`timescale 1ns/1ps

module tb_uart_top
    import uart_pkg::*;
;

    localparam int RESET_CYCLES    = 4;
    localparam int FRAME_CYCLES    = FRAME_BITS * CLOCKS_PER_BIT;
    localparam int LOOPBACK_FRAMES = 16;
    // frames over all tests: 1 tx, 16 loopback, parity, framing, glitch window, good frame
    localparam int FRAME_COUNT     = 21;
    localparam int TIMEOUT_CYCLES  = FRAME_COUNT * 100 + 300;

    logic       clk = 1'b0;
    logic       reset;
    logic       i_enable;
    uart_byte_t i_data;
    logic       i_loopback;
    logic       i_serial_in;
    logic       o_busy;
    logic       o_serial_out;
    logic       o_rx_valid;
    rx_status_t o_rx_status;

    int          check_count = 0;
    int          error_count = 0;
    int          cycle_count = 0;
    int          valid_count = 0;  // every rx valid pulse seen
    logic [31:0] lfsr_q      = 32'h596af556;

    always #50 clk = ~clk;  // 100 ns period

    uart_top uart_top_i (
        .clk          (clk),
        .reset        (reset),
        .i_enable     (i_enable),
        .i_data       (i_data),
        .o_busy       (o_busy),
        .o_serial_out (o_serial_out),
        .i_loopback   (i_loopback),
        .i_serial_in  (i_serial_in),
        .o_rx_valid   (o_rx_valid),
        .o_rx_status  (o_rx_status)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // one lfsr step per bit taken
    function automatic uart_byte_t random_byte();
        uart_byte_t value;
        int         i;
        for (i = 0; i < DATA_BITS; i++) begin
            lfsr_q   = lfsr_next(lfsr_q);
            value[i] = lfsr_q[0];
        end
        return value;
    endfunction

    `include "tb_uart_tasks.svh"

    // valid is one cycle wide, so one falling-edge sample per pulse
    always @(negedge clk) begin
        if (o_rx_valid) begin
            valid_count <= valid_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, tests did not finish", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        i_enable    = 1'b0;
        i_data      = '0;
        i_loopback  = 1'b0;
        i_serial_in = 1'b1;  // external line idles high
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        reset_idle_levels();
        idle_cycles(10);
        tx_frame_waveform();
        idle_cycles(10);
        loopback_round_trip();
        idle_cycles(10);
        parity_error_report();
        idle_cycles(10);
        framing_error_report();
        idle_cycles(10);
        glitch_rejection();
        idle_cycles(10);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
